// File: Bender.yml
package:
  name: memSubsys

sources:
  - memPkg.sv
  - memCtrl.sv
  - instFetch.sv
  - dataPort.sv
  - byteRam.sv
  - memSubsys.sv
  - target: test
    files:
      - memSubsys_tb.sv

// File: byteRam.sv
`timescale 1ns/1ps

module byteRam (
    input  logic          clk,
    input  memPkg::addr_t memAddr,
    input  logic          memWe,
    input  memPkg::byte_t memWdata,
    output memPkg::byte_t memRdata
);

    memPkg::byte_t mem [memPkg::ramDepth];

    // simulation starts from a cleared array
    initial begin
        for (int i = 0; i < memPkg::ramDepth; i++) begin
            mem[i] = '0;
        end
    end

    // read during write returns the old byte
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWdata;
        end
        memRdata <= mem[memAddr];
    end

endmodule

// File: dataPort.sv
`timescale 1ns/1ps

module dataPort (
    input  logic               clk,
    input  logic               rst,
    input  logic               lsuReq,
    input  logic               lsuStore,
    input  memPkg::len_t       lsuLen,
    input  logic               lsuSigned,
    input  memPkg::addr_t      lsuAddr,
    input  memPkg::word_t      lsuWdata,
    output logic               lsuBusy,
    output logic               lsuDone,
    output memPkg::word_t      lsuRdata,
    output logic               dataReq,
    output memPkg::accessDir_e dataDir,
    output memPkg::len_t       dataLen,
    output memPkg::addr_t      dataAddr,
    output memPkg::word_t      dataWrite,
    input  logic               dataDone,
    input  memPkg::word_t      dataRead
);

    typedef enum logic {
        stIdle,
        stActive
    } portState_e;

    portState_e    state;
    logic          signedQ;
    memPkg::word_t extended;

    assign lsuBusy = (state == stActive);
    assign dataReq = (state == stActive);

    // controller returns the bytes zero extended
    always_comb begin
        case (dataLen)
            3'd1: extended = {{24{signedQ & dataRead[7]}}, dataRead[7:0]};
            3'd2: extended = {{16{signedQ & dataRead[15]}}, dataRead[15:0]};
            default: extended = dataRead;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            lsuDone <= 1'b0;
        end else begin
            lsuDone <= 1'b0;
            if (state == stIdle && lsuReq) begin
                state <= stActive;
            end else if (state == stActive && dataDone) begin
                state   <= stIdle;
                lsuDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && lsuReq) begin
            dataDir   <= lsuStore ? memPkg::dirStore : memPkg::dirLoad;
            dataLen   <= lsuLen;
            dataAddr  <= lsuAddr;
            dataWrite <= lsuWdata;
            signedQ   <= lsuSigned;
        end
        if (state == stActive && dataDone) begin
            lsuRdata <= (dataDir == memPkg::dirStore) ? '0 : extended;
        end
    end

    noReqWhileBusy: assert property (@(posedge clk) disable iff (rst)
        lsuBusy |-> !lsuReq);

endmodule

// File: instFetch.sv
`timescale 1ns/1ps

module instFetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetchEn,
    input  logic          redirect,
    input  memPkg::addr_t redirectPc,
    output logic          fetchReq,
    output memPkg::addr_t fetchAddr,
    input  logic          fetchDone,
    input  memPkg::word_t fetchWord,
    output logic          instValid,
    output memPkg::word_t inst,
    output memPkg::addr_t instPc
);

    memPkg::addr_t pc;
    memPkg::addr_t redirPc;
    logic          flush;

    assign fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= memPkg::resetPc;
            fetchReq  <= 1'b0;
            flush     <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= 1'b0;
            if (fetchReq && fetchDone) begin
                fetchReq <= 1'b0;
                flush    <= 1'b0;
                if (redirect) begin
                    pc <= redirectPc;
                end else if (flush) begin
                    pc <= redirPc;
                end else begin
                    instValid <= 1'b1;
                    pc        <= pc + memPkg::instStep;
                end
            end else if (fetchReq) begin
                // address must stay put, so only note the redirect
                if (redirect) begin
                    flush <= 1'b1;
                end
            end else begin
                fetchReq <= fetchEn;
                if (redirect) begin
                    pc <= redirectPc;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq && fetchDone) begin
            inst   <= fetchWord;
            instPc <= pc;
        end
        if (fetchReq && !fetchDone && redirect) begin
            redirPc <= redirectPc;
        end
    end

    fetchAligned: assert property (@(posedge clk) disable iff (rst)
        fetchReq |-> fetchAddr[1:0] == 2'b00);

endmodule

// File: memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               ioFull,
    input  logic               fetchReq,
    input  memPkg::addr_t      fetchAddr,
    output logic               fetchDone,
    output memPkg::word_t      fetchWord,
    input  logic               dataReq,
    input  memPkg::accessDir_e dataDir,
    input  memPkg::len_t       dataLen,
    input  memPkg::addr_t      dataAddr,
    input  memPkg::word_t      dataWrite,
    output logic               dataDone,
    output memPkg::word_t      dataRead,
    output memPkg::addr_t      memAddr,
    output logic               memWe,
    output memPkg::byte_t      memWdata,
    input  memPkg::byte_t      memRdata,
    output memPkg::busOwner_e  busOwner
);

    memPkg::busOwner_e  owner;
    memPkg::stage_t     stage;
    memPkg::stage_t     addrStage;
    memPkg::stage_t     lane;
    memPkg::addr_t      base;
    memPkg::accessDir_e dirQ;
    memPkg::len_t       lenQ;
    memPkg::word_t      wdataQ;
    memPkg::word_t      assembly;
    logic               fetchDoneQ;
    logic               dataDoneQ;
    logic               arbOk;
    logic               grantData;
    logic               grantFetch;
    logic               isStore;
    logic               lastStep;

    assign busOwner = owner;

    // the finishing client still holds its request during the done cycle
    assign arbOk = (owner == memPkg::ownNone) && !fetchDoneQ && !dataDoneQ && !ioFull;
    assign grantData = arbOk && dataReq;
    assign grantFetch = arbOk && !dataReq && fetchReq;

    assign isStore = (owner == memPkg::ownData) && (dirQ == memPkg::dirStore);

    // stores end on the last write, loads one step later when the last byte returns
    assign lastStep = isStore ? (stage == memPkg::stage_t'(lenQ - 3'd1))
                              : (stage == memPkg::stage_t'(lenQ));

    // while stalled, re-read the previous byte so memRdata still matches the
    // stage once the stall lifts
    assign addrStage = ioFull ? stage - 3'd1 : stage;
    assign lane = stage - 3'd1;

    assign memAddr = base + memPkg::addr_t'(addrStage);
    assign memWe = isStore && !ioFull;
    assign memWdata = wdataQ[stage[1:0]*8 +: 8];

    assign fetchDone = fetchDoneQ && !ioFull;
    assign dataDone = dataDoneQ && !ioFull;
    assign fetchWord = assembly;
    assign dataRead = assembly;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= memPkg::ownNone;
            stage      <= '0;
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
        end else if (!ioFull) begin
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
            if (owner == memPkg::ownNone) begin
                stage <= '0;
                if (grantData) begin
                    owner <= memPkg::ownData;
                end else if (grantFetch) begin
                    owner <= memPkg::ownFetch;
                end
            end else if (lastStep) begin
                owner      <= memPkg::ownNone;
                stage      <= '0;
                fetchDoneQ <= (owner == memPkg::ownFetch);
                dataDoneQ  <= (owner == memPkg::ownData);
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ioFull) begin
            if (grantData) begin
                base     <= dataAddr;
                dirQ     <= dataDir;
                lenQ     <= dataLen;
                wdataQ   <= dataWrite;
                assembly <= '0;
            end else if (grantFetch) begin
                base     <= fetchAddr;
                dirQ     <= memPkg::dirLoad;
                lenQ     <= memPkg::wordLen;
                assembly <= '0;
            end else if (owner != memPkg::ownNone && dirQ == memPkg::dirLoad &&
                         stage != '0) begin
                // byte for the previous stage lands in its own lane
                assembly[lane[1:0]*8 +: 8] <= memRdata;
            end
        end
    end

    grantLenLegal: assert property (@(posedge clk) disable iff (rst)
        grantData |-> dataLen inside {3'd1, 3'd2, 3'd4});

    // a write needs the data port to still present a store
    writeOnlyInStore: assert property (@(posedge clk) disable iff (rst)
        memWe |-> (busOwner == memPkg::ownData) && dataReq &&
                  (dataDir == memPkg::dirStore));

    // a stall freezes the controller and holds back a pending done
    noDoneInStall: assert property (@(posedge clk) disable iff (rst)
        ioFull |=> $stable(owner) && $stable(stage) &&
                   $stable(fetchDoneQ) && $stable(dataDoneQ));

endmodule

// File: memPkg.sv
package memPkg;

    localparam int addrWidth = 17;
    localparam int ramDepth = 1 << addrWidth;

    typedef logic [addrWidth-1:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // bytes per access, only 1, 2 and 4 are legal
    typedef logic [2:0] len_t;

    // byte step inside one transaction
    typedef logic [2:0] stage_t;

    typedef enum logic {
        dirLoad,
        dirStore
    } accessDir_e;

    typedef enum logic [1:0] {
        ownNone,
        ownData,
        ownFetch
    } busOwner_e;

    // an instruction fetch is a 4-byte load
    localparam len_t wordLen = 3'd4;

    localparam addr_t resetPc = '0;
    localparam addr_t instStep = addr_t'(4);

endpackage

// File: memSubsys.f
memPkg.sv
memCtrl.sv
instFetch.sv
dataPort.sv
byteRam.sv
memSubsys.sv
memSubsys_tb.sv

// File: memSubsys.sv
`timescale 1ns/1ps

module memSubsys (
    input  logic              clk,
    input  logic              rst,
    input  logic              ioFull,
    output memPkg::busOwner_e busOwner,
    input  logic              fetchEn,
    input  logic              redirect,
    input  memPkg::addr_t     redirectPc,
    output logic              instValid,
    output memPkg::word_t     inst,
    output memPkg::addr_t     instPc,
    input  logic              lsuReq,
    input  logic              lsuStore,
    input  memPkg::len_t      lsuLen,
    input  logic              lsuSigned,
    input  memPkg::addr_t     lsuAddr,
    input  memPkg::word_t     lsuWdata,
    output logic              lsuBusy,
    output logic              lsuDone,
    output memPkg::word_t     lsuRdata
);

    logic               fetchReq;
    memPkg::addr_t      fetchAddr;
    logic               fetchDone;
    memPkg::word_t      fetchWord;
    logic               dataReq;
    memPkg::accessDir_e dataDir;
    memPkg::len_t       dataLen;
    memPkg::addr_t      dataAddr;
    memPkg::word_t      dataWrite;
    logic               dataDone;
    memPkg::word_t      dataRead;
    memPkg::addr_t      memAddr;
    logic               memWe;
    memPkg::byte_t      memWdata;
    memPkg::byte_t      memRdata;

    instFetch instFetch_inst (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchWord  (fetchWord),
        .instValid  (instValid),
        .inst       (inst),
        .instPc     (instPc)
    );

    dataPort dataPort_inst (
        .clk       (clk),
        .rst       (rst),
        .lsuReq    (lsuReq),
        .lsuStore  (lsuStore),
        .lsuLen    (lsuLen),
        .lsuSigned (lsuSigned),
        .lsuAddr   (lsuAddr),
        .lsuWdata  (lsuWdata),
        .lsuBusy   (lsuBusy),
        .lsuDone   (lsuDone),
        .lsuRdata  (lsuRdata),
        .dataReq   (dataReq),
        .dataDir   (dataDir),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead)
    );

    memCtrl memCtrl_inst (
        .clk       (clk),
        .rst       (rst),
        .ioFull    (ioFull),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchWord (fetchWord),
        .dataReq   (dataReq),
        .dataDir   (dataDir),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .busOwner  (busOwner)
    );

    byteRam byteRam_inst (
        .clk      (clk),
        .memAddr  (memAddr),
        .memWe    (memWe),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

// File: memSubsys_tb.sv
`timescale 1ns/1ps

module memSubsys_tb;

    localparam int progWords = 16;
    localparam memPkg::addr_t winBase = 17'h10000;

    logic              clk;
    logic              rst;
    logic              ioFull;
    memPkg::busOwner_e busOwner;
    logic              fetchEn;
    logic              redirect;
    memPkg::addr_t     redirectPc;
    logic              instValid;
    memPkg::word_t     inst;
    memPkg::addr_t     instPc;
    logic              lsuReq;
    logic              lsuStore;
    memPkg::len_t      lsuLen;
    logic              lsuSigned;
    memPkg::addr_t     lsuAddr;
    memPkg::word_t     lsuWdata;
    logic              lsuBusy;
    logic              lsuDone;
    memPkg::word_t     lsuRdata;

    memPkg::byte_t shadow [memPkg::ramDepth];
    memPkg::word_t expRdata;
    memPkg::addr_t expPc;
    string         testName;
    integer        seed;
    int            loadErrors;
    int            fetchErrors;
    int            timingErrors;
    int            protocolErrors;

    memSubsys memSubsys_inst (
        .clk        (clk),
        .rst        (rst),
        .ioFull     (ioFull),
        .busOwner   (busOwner),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instValid  (instValid),
        .inst       (inst),
        .instPc     (instPc),
        .lsuReq     (lsuReq),
        .lsuStore   (lsuStore),
        .lsuLen     (lsuLen),
        .lsuSigned  (lsuSigned),
        .lsuAddr    (lsuAddr),
        .lsuWdata   (lsuWdata),
        .lsuBusy    (lsuBusy),
        .lsuDone    (lsuDone),
        .lsuRdata   (lsuRdata)
    );

    always #50 clk = ~clk;

    // little-endian bytes from the shadow, then zero or sign extension
    function automatic memPkg::word_t loadValue(input memPkg::addr_t addr,
                                                input memPkg::len_t len, input logic sgn);
        memPkg::word_t raw;
        raw = {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
        if (len == 3'd1) begin
            return sgn ? 32'(signed'(raw[7:0])) : 32'(raw[7:0]);
        end
        if (len == 3'd2) begin
            return sgn ? 32'(signed'(raw[15:0])) : 32'(raw[15:0]);
        end
        return raw;
    endfunction

    function automatic memPkg::len_t pickLen();
        int pick;
        pick = $unsigned($random(seed)) % 3;
        return (pick == 0) ? 3'd1 : (pick == 1) ? 3'd2 : 3'd4;
    endfunction

    function automatic memPkg::addr_t windowAddr();
        return winBase + memPkg::addr_t'($unsigned($random(seed)) % 64);
    endfunction

    // next pc the fetch stream has to show
    always @(posedge clk) begin
        if (rst) begin
            expPc <= memPkg::resetPc;
        end else if (redirect) begin
            expPc <= redirectPc;
        end else if (instValid) begin
            expPc <= expPc + memPkg::instStep;
        end
    end

    resetQuiet: assert property (@(posedge clk)
        rst |=> busOwner == memPkg::ownNone && !instValid && !lsuDone)
        else begin
            protocolErrors++;
            $display("%s: bus owned or client output active during reset", testName);
        end

    loadMatches: assert property (@(posedge clk) disable iff (rst)
        lsuDone |-> lsuRdata == expRdata)
        else begin
            loadErrors++;
            $display("** Error %s: lsuRdata expected %h, actual %h", testName,
                     $sampled(expRdata), $sampled(lsuRdata));
        end

    instMatches: assert property (@(posedge clk) disable iff (rst)
        instValid |-> inst == loadValue(instPc, 3'd4, 1'b0))
        else begin
            fetchErrors++;
            $display("** Error %s: inst expected %h, actual %h", testName,
                     loadValue($sampled(instPc), 3'd4, 1'b0), $sampled(inst));
        end

    pcSequence: assert property (@(posedge clk) disable iff (rst)
        instValid |-> instPc == expPc)
        else begin
            fetchErrors++;
            $display("** Error %s: instPc expected %h, actual %h", testName,
                     $sampled(expPc), $sampled(instPc));
        end

    ownerThroughNone: assert property (@(posedge clk) disable iff (rst)
        busOwner == memPkg::ownFetch |=> busOwner != memPkg::ownData)
        else begin
            protocolErrors++;
            $display("%s: bus went from fetch to data without a free cycle", testName);
        end

    // an idle port goes busy exactly when it took a request
    busyOnAccept: assert property (@(posedge clk) disable iff (rst)
        !lsuBusy |=> lsuBusy == $past(lsuReq))
        else begin
            protocolErrors++;
            $display("%s: load/store busy did not follow the request", testName);
        end

    busyUntilDone: assert property (@(posedge clk) disable iff (rst)
        lsuBusy |=> lsuBusy || lsuDone)
        else begin
            protocolErrors++;
            $display("%s: load/store busy dropped before the done pulse", testName);
        end

    // client outputs trail the controller done by one cycle
    quietAfterStall: assert property (@(posedge clk) disable iff (rst)
        ioFull |=> !lsuDone && !instValid)
        else begin
            protocolErrors++;
            $display("%s: a result came out of a stalled cycle", testName);
        end

    task automatic reportTimeout(input string what);
        $display("timeout waiting for %s in %s", what, testName);
        $display("errors: load %0d, fetch %0d, timing %0d, protocol %0d",
                 loadErrors, fetchErrors, timingErrors, protocolErrors);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic lsuAccess(input logic store, input memPkg::len_t len, input logic sgn,
                             input memPkg::addr_t addr, input memPkg::word_t wdata,
                             input logic checkTime);
        int cycles;
        int i;
        @(posedge clk);
        lsuReq    <= 1'b1;
        lsuStore  <= store;
        lsuLen    <= len;
        lsuSigned <= sgn;
        lsuAddr   <= addr;
        lsuWdata  <= wdata;
        expRdata = store ? '0 : loadValue(addr, len, sgn);
        @(posedge clk);
        lsuReq <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!lsuDone && cycles < 300) begin
            @(negedge clk);
            cycles++;
        end
        if (!lsuDone) begin
            reportTimeout("lsuDone");
        end
        if (store) begin
            for (i = 0; i < int'(len); i++) begin
                shadow[addr + memPkg::addr_t'(i)] = wdata[8*i +: 8];
            end
        end
        // latch, grant, one address per byte, read latency, done register
        if (checkTime && !store) begin
            loadLatency: assert (cycles == int'(len) + 4)
                else begin
                    timingErrors++;
                    $display("** Error %s: load latency expected %0d, actual %0d",
                             testName, int'(len) + 4, cycles);
                end
        end
    endtask

    task automatic randomLoad(input logic checkTime);
        lsuAccess(1'b0, pickLen(), $random(seed) & 1, windowAddr(), '0, checkTime);
    endtask

    task automatic waitInst(input int count);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count && cycles < count * 40) begin
            @(negedge clk);
            cycles++;
            if (instValid) begin
                seen++;
            end
        end
        if (seen < count) begin
            reportTimeout("instValid");
        end
    endtask

    task automatic driveStalls(input int rounds);
        int len;
        repeat (rounds) begin
            len = $unsigned($random(seed)) % 6 + 1;
            @(posedge clk);
            ioFull <= 1'b1;
            repeat (len) @(posedge clk);
            ioFull <= 1'b0;
            len = $unsigned($random(seed)) % 10 + 1;
            repeat (len) @(posedge clk);
        end
    endtask

    initial begin
        seed = 53;
        clk = 1'b0;
        rst = 1'b1;
        ioFull = 1'b0;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        lsuReq = 1'b0;
        lsuStore = 1'b0;
        lsuLen = 3'd4;
        lsuSigned = 1'b0;
        lsuAddr = '0;
        lsuWdata = '0;
        expRdata = '0;
        loadErrors = 0;
        fetchErrors = 0;
        timingErrors = 0;
        protocolErrors = 0;
        for (int i = 0; i < memPkg::ramDepth; i++) begin
            shadow[i] = '0;
        end
        testName = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        testName = "program";
        for (int i = 0; i < progWords; i++) begin
            lsuAccess(1'b1, 3'd4, 1'b0, memPkg::addr_t'(i * 4), $random(seed), 1'b0);
        end

        testName = "store/load";
        repeat (30) begin
            lsuAccess(1'b1, pickLen(), 1'b0, windowAddr(), $random(seed), 1'b0);
            randomLoad(1'b1);
        end

        testName = "fetch";
        @(posedge clk);
        fetchEn <= 1'b1;
        waitInst(progWords);

        testName = "redirect";
        repeat (3) begin
            repeat ($unsigned($random(seed)) % 8 + 1) @(posedge clk);
            redirect   <= 1'b1;
            redirectPc <= memPkg::addr_t'(($unsigned($random(seed)) % progWords) * 4);
            @(posedge clk);
            redirect <= 1'b0;
            waitInst(4);
        end

        testName = "contention";
        repeat (20) randomLoad(1'b0);
        waitInst(4);

        testName = "stall";
        fork
            driveStalls(25);
            repeat (15) randomLoad(1'b0);
        join
        waitInst(4);

        $display("errors: load %0d, fetch %0d, timing %0d, protocol %0d",
                 loadErrors, fetchErrors, timingErrors, protocolErrors);
        if (loadErrors + fetchErrors + timingErrors + protocolErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
